// File: compile.f
+incdir+.
adpll_cfg_pkg.sv
adpll_loop_pkg.sv
adpll_cfg_if.sv
adpll_config_regs.sv
phase_detector.sv
error_combiner.sv
loop_filter.sv
dco_nco.sv
adpll_node_top.sv
tb_adpll_node.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the node testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_adpll_node -f compile.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_adpll_node > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "no result found in $LOG"
    exit 1
fi
exit 0

// File: tb_adpll_node.sv
`timescale 1ns/1ps

`include "adpll_macros.svh"

module tb_adpll_node;

    localparam int TIMEOUT = 5000;

    typedef struct {
        int kp;
        int ki;
        int wr;
        int wb;
        int er;
        int eb;
        int ticks;
    } entry_t;

    logic                                  clk;
    logic                                  rst_i;
    logic                                  cfg_valid_i;
    logic [`ADPLL_CFG_ADDR_WIDTH-1:0]      cfg_addr_i;
    logic [`ADPLL_CFG_DATA_WIDTH-1:0]      cfg_data_i;
    logic                                  ref_left_i;
    logic                                  ref_above_i;
    logic signed [`ADPLL_PDET_WIDTH-1:0]   error_right_i;
    logic signed [`ADPLL_PDET_WIDTH-1:0]   error_bottom_i;
    logic                                  cfg_ready_o;
    logic                                  gen_clk_o;
    logic                                  gen_div8_o;
    logic signed [`ADPLL_PDET_WIDTH-1:0]   error_left_o;
    logic signed [`ADPLL_PDET_WIDTH-1:0]   error_above_o;
    logic signed [`ADPLL_DCO_CC_WIDTH-1:0] dco_cc_o;
    logic                                  dco_update_o;

    entry_t      table_q [5];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          model_integ;
    int          rel;
    logic [31:0] rng;

    adpll_node_top UUT (
        .fpga_clk_i     (clk),
        .rst_i          (rst_i),
        .cfg_valid_i    (cfg_valid_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_data_i     (cfg_data_i),
        .ref_left_i     (ref_left_i),
        .ref_above_i    (ref_above_i),
        .error_right_i  (error_right_i),
        .error_bottom_i (error_bottom_i),
        .cfg_ready_o    (cfg_ready_o),
        .gen_clk_o      (gen_clk_o),
        .gen_div8_o     (gen_div8_o),
        .error_left_o   (error_left_o),
        .error_above_o  (error_above_o),
        .dco_cc_o       (dco_cc_o),
        .dco_update_o   (dco_update_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v > hi) return hi;
        if (v < lo) return lo;
        return v;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
        errors++;
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: PASS", name);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [15:0] data);
        @(posedge clk);
        cfg_valid_i <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_data_i  <= data;
        @(negedge clk);
        if (cfg_ready_o !== 1'b1) report_mismatch("cfg_ready_o", 1, cfg_ready_o);
        @(posedge clk);
        cfg_valid_i <= 1'b0;
    endtask

    task automatic wait_update();
        int n;
        n = 0;
        @(negedge clk);
        while (dco_update_o !== 1'b1 && n <= TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n > TIMEOUT) abort_on_timeout("a dco_update_o pulse");
    endtask

    task automatic wait_div8_rise();
        int   n;
        logic prev;
        n = 0;
        @(negedge clk);
        prev = gen_div8_o;
        @(negedge clk);
        while (!(gen_div8_o && !prev) && n <= TIMEOUT) begin
            prev = gen_div8_o;
            n++;
            @(negedge clk);
        end
        if (n > TIMEOUT) abort_on_timeout("a gen_div8_o rising edge");
    endtask

    // advance to a posedge counted from the last divided edge.
    task automatic step_to(input int target);
        while (rel < target) begin
            @(posedge clk);
            rel++;
        end
    endtask

    task automatic pulse_refs(input int at);
        step_to(at);
        ref_left_i  <= 1'b1;
        ref_above_i <= 1'b1;
        step_to(at + 4);
        ref_left_i  <= 1'b0;
        ref_above_i <= 1'b0;
    endtask

    task automatic check_errors_out(input int expected);
        @(negedge clk);
        if (error_left_o !== expected[7:0]) begin
            report_mismatch("error_left_o", expected, error_left_o);
        end
        if (error_above_o !== expected[7:0]) begin
            report_mismatch("error_above_o", expected, error_above_o);
        end
    endtask

    // PI law on one tick, left and above weights are zero.
    task automatic model_tick(input int kp, input int ki, input int wr, input int wb,
                              input int er, input int eb, output int cc);
        int comb;
        comb = clamp((wr * er + wb * eb) >>> 2, -127, 127);
        model_integ = clamp(model_integ + ki * comb, -32768, 32767);
        cc = clamp(((kp * comb) >>> 1) + (model_integ >>> 3), -255, 255);
    endtask

    task automatic set_loop(input int kp, input int ki, input int wr, input int wb);
        // reserved gain bits set on purpose.
        cfg_write(2'd0, 16'hFF08 | 16'((ki << 4) | kp));
        cfg_write(2'd1, 16'((wb << 12) | (wr << 8)));
    endtask

    initial begin
        int e0;
        int n_edges;
        int n_clk;
        int expected;
        int cc;
        int prev_cc;
        int first_cc;
        int er;
        int eb;
        logic prev;
        logic prev_clk;

        clk            = 1'b0;
        rst_i          = 1'b1;
        cfg_valid_i    = 1'b0;
        cfg_addr_i     = '0;
        cfg_data_i     = '0;
        ref_left_i     = 1'b0;
        ref_above_i    = 1'b0;
        error_right_i  = '0;
        error_bottom_i = '0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        model_integ    = 0;
        rng            = 32'd17;

        table_q[0] = '{kp: 2, ki: 8,  wr: 4,  wb: 0,  er: 10,   eb: 0,    ticks: 4};
        table_q[1] = '{kp: 1, ki: 0,  wr: 4,  wb: 4,  er: -20,  eb: 7,    ticks: 3};
        table_q[2] = '{kp: 0, ki: 3,  wr: 2,  wb: 9,  er: 33,   eb: -50,  ticks: 3};
        table_q[3] = '{kp: 7, ki: 15, wr: 15, wb: 15, er: 127,  eb: 127,  ticks: 6};
        table_q[4] = '{kp: 7, ki: 15, wr: 15, wb: 15, er: -128, eb: -128, ticks: 30};

        ////////////////////////////////////////////////////////////////////
        // reset and handshake.
        ////////////////////////////////////////////////////////////////////
        e0 = errors;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (cfg_ready_o !== 1'b0) report_mismatch("cfg_ready_o", 0, cfg_ready_o);
        if (gen_clk_o !== 1'b0) report_mismatch("gen_clk_o", 0, gen_clk_o);
        if (gen_div8_o !== 1'b0) report_mismatch("gen_div8_o", 0, gen_div8_o);
        if (dco_update_o !== 1'b0) report_mismatch("dco_update_o", 0, dco_update_o);
        if (error_left_o !== 8'sd0) report_mismatch("error_left_o", 0, error_left_o);
        if (error_above_o !== 8'sd0) report_mismatch("error_above_o", 0, error_above_o);
        if (dco_cc_o !== 9'sd0) report_mismatch("dco_cc_o", 0, dco_cc_o);
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        repeat (2) @(posedge clk);
        cfg_write(2'd0, 16'h0000);
        cfg_write(2'd1, 16'h0000);
        cfg_write(2'd2, 16'd256);
        cfg_write(2'd3, 16'h0001);
        close_test("reset_handshake", e0);

        // open loop, 256 per cycle gives one divided edge per 128 cycles.
        e0 = errors;
        n_edges = 0;
        n_clk   = 0;
        @(negedge clk);
        prev     = gen_div8_o;
        prev_clk = gen_clk_o;
        repeat (4096) begin
            @(negedge clk);
            if (gen_div8_o && !prev) n_edges++;
            if (gen_clk_o && !prev_clk) n_clk++;
            prev     = gen_div8_o;
            prev_clk = gen_clk_o;
        end
        expected = 4096 * 256 / 4096;
        if (n_clk > expected + 1 || n_clk < expected - 1) begin
            report_mismatch("gen_clk_o edges", expected, n_clk);
        end
        expected = 4096 * 256 / 32768;
        if (n_edges > expected + 1 || n_edges < expected - 1) begin
            report_mismatch("gen_div8_o edges", expected, n_edges);
        end
        close_test("open_loop", e0);

        e0 = errors;
        cfg_write(2'd3, 16'h0000);
        n_edges = 0;
        @(negedge clk);
        prev = gen_div8_o;
        repeat (512) begin
            @(negedge clk);
            if (gen_div8_o && !prev) n_edges++;
            prev = gen_div8_o;
        end
        if (n_edges != 0) report_mismatch("gen_div8_o edges", 0, n_edges);
        close_test("disabled", e0);

        ////////////////////////////////////////////////////////////////////
        // phase detectors.
        ////////////////////////////////////////////////////////////////////
        e0 = errors;
        // both detectors lag far behind the last divided edge.
        rel = 0;
        pulse_refs(1);
        step_to(12);
        check_errors_out(-127);
        cfg_write(2'd3, 16'h0001);
        wait_div8_rise();
        rel = 0;
        pulse_refs(10);
        step_to(20);
        check_errors_out(-10);
        pulse_refs(128 - 5);
        step_to(128 + 8);
        check_errors_out(5);
        pulse_refs(256 + 5);
        step_to(256 + 5 + 10);
        check_errors_out(-5);
        close_test("phase_detector", e0);

        ////////////////////////////////////////////////////////////////////
        // table driven combiner and filter.
        ////////////////////////////////////////////////////////////////////
        cfg_write(2'd2, 16'd1024);
        // line up the gain writes just after a tick.
        wait_update();
        for (int i = 0; i < 5; i++) begin
            e0 = errors;
            set_loop(table_q[i].kp, table_q[i].ki, table_q[i].wr, table_q[i].wb);
            @(posedge clk);
            error_right_i  <= 8'(table_q[i].er);
            error_bottom_i <= 8'(table_q[i].eb);
            for (int t = 0; t < table_q[i].ticks; t++) begin
                wait_update();
                model_tick(table_q[i].kp, table_q[i].ki, table_q[i].wr, table_q[i].wb,
                           table_q[i].er, table_q[i].eb, cc);
                if (dco_cc_o !== 9'(cc)) report_mismatch("dco_cc_o", cc, dco_cc_o);
            end
            close_test($sformatf("table_%0d", i), e0);
        end

        // closed loop, steady positive error drives the word upward.
        e0 = errors;
        set_loop(7, 15, 15, 15);
        @(posedge clk);
        error_right_i  <= 8'sd127;
        error_bottom_i <= 8'sd127;
        first_cc = dco_cc_o;
        prev_cc  = first_cc;
        for (int t = 0; t < 24; t++) begin
            wait_update();
            model_tick(7, 15, 15, 15, 127, 127, cc);
            if (dco_cc_o !== 9'(cc)) report_mismatch("dco_cc_o", cc, dco_cc_o);
            if (dco_cc_o < prev_cc) report_mismatch("dco_cc_o direction", prev_cc, dco_cc_o);
            prev_cc = dco_cc_o;
        end
        if (prev_cc <= first_cc) begin
            $display("dco_cc_o did not rise under a steady positive error");
            errors++;
        end
        close_test("closed_loop", e0);

        e0 = errors;
        set_loop(3, 2, 6, 5);
        for (int t = 0; t < 16; t++) begin
            rng = xorshift(rng);
            er  = $signed(rng[7:0]);
            eb  = $signed(rng[15:8]);
            @(posedge clk);
            error_right_i  <= 8'(er);
            error_bottom_i <= 8'(eb);
            wait_update();
            model_tick(3, 2, 6, 5, er, eb, cc);
            if (dco_cc_o !== 9'(cc)) report_mismatch("dco_cc_o", cc, dco_cc_o);
        end
        close_test("random_errors", e0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: adpll_node_top.sv
`timescale 1ns/1ps

`include "adpll_macros.svh"

module adpll_node_top (
    input  logic                                    fpga_clk_i,
    input  logic                                    rst_i,
    input  logic                                    cfg_valid_i,
    input  logic [`ADPLL_CFG_ADDR_WIDTH-1:0]        cfg_addr_i,
    input  logic [`ADPLL_CFG_DATA_WIDTH-1:0]        cfg_data_i,
    input  logic                                    ref_left_i,
    input  logic                                    ref_above_i,
    input  logic signed [`ADPLL_PDET_WIDTH-1:0]     error_right_i,
    input  logic signed [`ADPLL_PDET_WIDTH-1:0]     error_bottom_i,
    output logic                                    cfg_ready_o,
    output logic                                    gen_clk_o,
    output logic                                    gen_div8_o,
    output logic signed [`ADPLL_PDET_WIDTH-1:0]     error_left_o,
    output logic signed [`ADPLL_PDET_WIDTH-1:0]     error_above_o,
    output logic signed [`ADPLL_DCO_CC_WIDTH-1:0]   dco_cc_o,
    output logic                                    dco_update_o
);

    adpll_loop_pkg::phase_err_t error_comb;
    logic                       update_tick;

    adpll_cfg_if cfg_bus ();

    adpll_config_regs u_config_regs (
        .fpga_clk_i  (fpga_clk_i),
        .rst_i       (rst_i),
        .cfg_valid_i (cfg_valid_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_ready_o (cfg_ready_o),
        .cfg         (cfg_bus.regs)
    );

    // local errors also go out to the neighbouring nodes.
    phase_detector u_pdet_left (
        .fpga_clk_i  (fpga_clk_i),
        .rst_i       (rst_i),
        .reference_i (ref_left_i),
        .generated_i (gen_div8_o),
        .error_o     (error_left_o)
    );

    phase_detector u_pdet_above (
        .fpga_clk_i  (fpga_clk_i),
        .rst_i       (rst_i),
        .reference_i (ref_above_i),
        .generated_i (gen_div8_o),
        .error_o     (error_above_o)
    );

    error_combiner u_error_combiner (
        .fpga_clk_i    (fpga_clk_i),
        .rst_i         (rst_i),
        .error_left_i  (error_left_o),
        .error_above_i (error_above_o),
        .error_right_i (error_right_i),
        .error_below_i (error_bottom_i),
        .cfg           (cfg_bus.loop),
        .error_o       (error_comb)
    );

    loop_filter u_loop_filter (
        .fpga_clk_i   (fpga_clk_i),
        .rst_i        (rst_i),
        .update_i     (update_tick),
        .error_i      (error_comb),
        .cfg          (cfg_bus.loop),
        .dco_cc_o     (dco_cc_o),
        .dco_update_o (dco_update_o)
    );

    dco_nco u_dco_nco (
        .fpga_clk_i (fpga_clk_i),
        .rst_i      (rst_i),
        .dco_cc_i   (dco_cc_o),
        .cfg        (cfg_bus.loop),
        .gen_clk_o  (gen_clk_o),
        .gen_div8_o (gen_div8_o),
        .update_o   (update_tick)
    );

endmodule

// File: dco_nco.sv
`timescale 1ns/1ps

`include "adpll_macros.svh"

module dco_nco (
    input  logic                    fpga_clk_i,
    input  logic                    rst_i,
    input  adpll_loop_pkg::dco_cc_t dco_cc_i,
    adpll_cfg_if.loop               cfg,
    output logic                    gen_clk_o,
    output logic                    gen_div8_o,
    output logic                    update_o
);

    localparam int PAD_W = `ADPLL_ACCUM_WIDTH - `ADPLL_DCO_CC_WIDTH;

    logic [`ADPLL_ACCUM_WIDTH-1:0] accum_q;
    logic [`ADPLL_ACCUM_WIDTH-1:0] step;
    logic [2:0]                    div_cnt_q;
    logic                          gen_clk_q;
    logic                          gen_div8_q;
    logic                          gen_clk_rise;

    // bias plus sign-extended control word, wraps modulo 2^12.
    assign step = cfg.bias + {{PAD_W{dco_cc_i[`ADPLL_DCO_CC_WIDTH-1]}}, dco_cc_i};

    assign gen_clk_o    = accum_q[`ADPLL_ACCUM_WIDTH-1];
    assign gen_clk_rise = gen_clk_o & ~gen_clk_q;
    assign gen_div8_o   = div_cnt_q[2];

    // one tick on the cycle the divided output goes high.
    assign update_o = gen_div8_o & ~gen_div8_q;

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            accum_q    <= '0;
            div_cnt_q  <= '0;
            gen_clk_q  <= 1'b0;
            gen_div8_q <= 1'b0;
        end else begin
            gen_clk_q  <= gen_clk_o;
            gen_div8_q <= gen_div8_o;
            if (cfg.enable) begin
                accum_q <= accum_q + step;
                if (gen_clk_rise) begin
                    div_cnt_q <= div_cnt_q + 3'd1;
                end
            end
        end
    end

endmodule

// File: loop_filter.sv
`timescale 1ns/1ps

`include "adpll_macros.svh"

module loop_filter (
    input  logic                       fpga_clk_i,
    input  logic                       rst_i,
    input  logic                       update_i,
    input  adpll_loop_pkg::phase_err_t error_i,
    adpll_cfg_if.loop                  cfg,
    output adpll_loop_pkg::dco_cc_t    dco_cc_o,
    output logic                       dco_update_o
);

    localparam int KP_PROD_W = `ADPLL_PDET_WIDTH + `ADPLL_KP_WIDTH + 1;
    localparam int KI_PROD_W = `ADPLL_PDET_WIDTH + `ADPLL_KI_WIDTH + 1;
    localparam int SUM_W     = `ADPLL_INTEG_WIDTH + 1;
    localparam int INTEG_MAX = 2 ** (`ADPLL_INTEG_WIDTH - 1) - 1;
    localparam int INTEG_MIN = -(2 ** (`ADPLL_INTEG_WIDTH - 1));
    localparam int CC_MAX    = 2 ** (`ADPLL_DCO_CC_WIDTH - 1) - 1;

    adpll_loop_pkg::integ_t       integ_q;
    adpll_loop_pkg::integ_t       integ_new;
    adpll_loop_pkg::dco_cc_t      cc_new;
    logic signed [KP_PROD_W-1:0]  kp_prod;
    logic signed [KI_PROD_W-1:0]  ki_prod;
    logic signed [KP_PROD_W-1:0]  p_part;
    logic signed [`ADPLL_INTEG_WIDTH-1:0] i_part;
    logic signed [SUM_W-1:0]      integ_sum;
    logic signed [SUM_W-1:0]      cc_sum;

    assign kp_prod = error_i * $signed({1'b0, cfg.kp});
    assign ki_prod = error_i * $signed({1'b0, cfg.ki});

    //////////////////////////////////////////////////////////////////////
    // integral path.
    //////////////////////////////////////////////////////////////////////

    assign integ_sum = integ_q + ki_prod;

    always_comb begin
        if (integ_sum > INTEG_MAX) begin
            integ_new = adpll_loop_pkg::integ_t'(INTEG_MAX);
        end else if (integ_sum < INTEG_MIN) begin
            integ_new = adpll_loop_pkg::integ_t'(INTEG_MIN);
        end else begin
            integ_new = integ_sum[`ADPLL_INTEG_WIDTH-1:0];
        end
    end

    // drop the fractional bits of each gain.
    assign p_part = kp_prod >>> `ADPLL_KP_FRAC;
    assign i_part = integ_new >>> `ADPLL_KI_FRAC;
    assign cc_sum = p_part + i_part;

    always_comb begin
        if (cc_sum > CC_MAX) begin
            cc_new = adpll_loop_pkg::dco_cc_t'(CC_MAX);
        end else if (cc_sum < -CC_MAX) begin
            cc_new = adpll_loop_pkg::dco_cc_t'(-CC_MAX);
        end else begin
            cc_new = cc_sum[`ADPLL_DCO_CC_WIDTH-1:0];
        end
    end

    // state only moves on an update tick.
    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            integ_q      <= '0;
            dco_cc_o     <= '0;
            dco_update_o <= 1'b0;
        end else begin
            dco_update_o <= update_i;
            if (update_i) begin
                integ_q  <= integ_new;
                dco_cc_o <= cc_new;
            end
        end
    end

endmodule

// File: error_combiner.sv
`timescale 1ns/1ps

`include "adpll_macros.svh"

module error_combiner (
    input  logic                       fpga_clk_i,
    input  logic                       rst_i,
    input  adpll_loop_pkg::phase_err_t error_left_i,
    input  adpll_loop_pkg::phase_err_t error_above_i,
    input  adpll_loop_pkg::phase_err_t error_right_i,
    input  adpll_loop_pkg::phase_err_t error_below_i,
    adpll_cfg_if.loop                  cfg,
    output adpll_loop_pkg::phase_err_t error_o
);

    localparam int PROD_W = `ADPLL_PDET_WIDTH + `ADPLL_WEIGHT_WIDTH + 1;
    localparam int SUM_W  = PROD_W + 2;
    localparam int ERR_MAX = 2 ** (`ADPLL_PDET_WIDTH - 1) - 1;

    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] scaled;

    // weight is unsigned, so widen with a zero before the signed multiply.
    function automatic logic signed [PROD_W-1:0] weigh(
        input adpll_loop_pkg::phase_err_t  err,
        input logic [`ADPLL_WEIGHT_WIDTH-1:0] w
    );
        return err * $signed({1'b0, w});
    endfunction

    assign sum = weigh(error_left_i, cfg.weight_left)
               + weigh(error_above_i, cfg.weight_above)
               + weigh(error_right_i, cfg.weight_right)
               + weigh(error_below_i, cfg.weight_below);

    // weights are in quarters.
    assign scaled = sum >>> `ADPLL_WEIGHT_SHIFT;

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            error_o <= '0;
        end else if (scaled > ERR_MAX) begin
            error_o <= adpll_loop_pkg::phase_err_t'(ERR_MAX);
        end else if (scaled < -ERR_MAX) begin
            error_o <= adpll_loop_pkg::phase_err_t'(-ERR_MAX);
        end else begin
            error_o <= scaled[`ADPLL_PDET_WIDTH-1:0];
        end
    end

endmodule

// File: phase_detector.sv
`timescale 1ns/1ps

`include "adpll_macros.svh"

module phase_detector (
    input  logic                      fpga_clk_i,
    input  logic                      rst_i,
    input  logic                      reference_i,
    input  logic                      generated_i,
    output adpll_loop_pkg::phase_err_t error_o
);

    localparam int CNT_W = `ADPLL_PDET_WIDTH - 1;

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_REF_LEAD = 2'd1;
    localparam logic [1:0] ST_GEN_LEAD = 2'd2;

    logic [2:0]       ref_sync_q;
    logic [2:0]       gen_dly_q;
    logic             ref_rise;
    logic             gen_rise;
    logic [1:0]       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_inc;

    // two-flop sync plus one for the edge; divided edge gets the same delay.
    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            ref_sync_q <= '0;
            gen_dly_q  <= '0;
        end else begin
            ref_sync_q <= {ref_sync_q[1:0], reference_i};
            gen_dly_q  <= {gen_dly_q[1:0], generated_i};
        end
    end

    assign ref_rise = ref_sync_q[1] & ~ref_sync_q[2];
    assign gen_rise = gen_dly_q[1] & ~gen_dly_q[2];

    // saturates at the largest magnitude.
    assign cnt_inc = (cnt_q == '1) ? cnt_q : cnt_q + CNT_W'(1);

    //////////////////////////////////////////////////////////////////////
    // lead/lag measurement.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            error_o <= '0;
        end else begin
            case (state_q)
                ST_REF_LEAD: begin
                    if (gen_rise) begin
                        error_o <= $signed({1'b0, cnt_q});
                        state_q <= ST_IDLE;
                    end else begin
                        cnt_q <= cnt_inc;
                    end
                end
                ST_GEN_LEAD: begin
                    if (ref_rise) begin
                        error_o <= -$signed({1'b0, cnt_q});
                        state_q <= ST_IDLE;
                    end else begin
                        cnt_q <= cnt_inc;
                    end
                end
                default: begin
                    cnt_q <= CNT_W'(1);
                    if (ref_rise && gen_rise) begin
                        // coincident edges, in phase.
                        error_o <= '0;
                    end else if (ref_rise) begin
                        state_q <= ST_REF_LEAD;
                    end else if (gen_rise) begin
                        state_q <= ST_GEN_LEAD;
                    end
                end
            endcase
        end
    end

endmodule

// File: adpll_config_regs.sv
`timescale 1ns/1ps

`include "adpll_macros.svh"

module adpll_config_regs (
    input  logic                              fpga_clk_i,
    input  logic                              rst_i,
    input  logic                              cfg_valid_i,
    input  logic [`ADPLL_CFG_ADDR_WIDTH-1:0]  cfg_addr_i,
    input  adpll_cfg_pkg::cfg_word_u          cfg_data_i,
    output logic                              cfg_ready_o,
    adpll_cfg_if.regs                         cfg
);

    logic ready_q;
    logic write_en;

    // no back-pressure once out of reset.
    assign cfg_ready_o = ready_q;
    assign write_en    = cfg_valid_i && ready_q;

    //////////////////////////////////////////////////////////////////////
    // register file.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            ready_q          <= 1'b0;
            cfg.kp           <= '0;
            cfg.ki           <= '0;
            cfg.weight_left  <= '0;
            cfg.weight_above <= '0;
            cfg.weight_right <= '0;
            cfg.weight_below <= '0;
            cfg.bias         <= adpll_cfg_pkg::BIAS_RESET;
            cfg.enable       <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            if (write_en) begin
                case (adpll_cfg_pkg::cfg_addr_e'(cfg_addr_i))
                    adpll_cfg_pkg::ADDR_GAIN: begin
                        // reserved bits are dropped.
                        cfg.kp <= cfg_data_i.gain.kp;
                        cfg.ki <= cfg_data_i.gain.ki;
                    end
                    adpll_cfg_pkg::ADDR_WEIGHT: begin
                        cfg.weight_left  <= cfg_data_i.weight.left;
                        cfg.weight_above <= cfg_data_i.weight.above;
                        cfg.weight_right <= cfg_data_i.weight.right;
                        cfg.weight_below <= cfg_data_i.weight.below;
                    end
                    adpll_cfg_pkg::ADDR_BIAS: begin
                        cfg.bias <= cfg_data_i[`ADPLL_ACCUM_WIDTH-1:0];
                    end
                    adpll_cfg_pkg::ADDR_CTRL: begin
                        cfg.enable <= cfg_data_i[0];
                    end
                endcase
            end
        end
    end

endmodule

// File: adpll_cfg_if.sv
`timescale 1ns/1ps

`include "adpll_macros.svh"

interface adpll_cfg_if;

    logic [`ADPLL_KP_WIDTH-1:0]     kp;
    logic [`ADPLL_KI_WIDTH-1:0]     ki;
    logic [`ADPLL_WEIGHT_WIDTH-1:0] weight_left;
    logic [`ADPLL_WEIGHT_WIDTH-1:0] weight_above;
    logic [`ADPLL_WEIGHT_WIDTH-1:0] weight_right;
    logic [`ADPLL_WEIGHT_WIDTH-1:0] weight_below;
    logic [`ADPLL_ACCUM_WIDTH-1:0]  bias;
    logic                           enable;

    modport regs (
        output kp, ki, weight_left, weight_above, weight_right, weight_below, bias, enable
    );

    modport loop (
        input kp, ki, weight_left, weight_above, weight_right, weight_below, bias, enable
    );

endinterface

// File: adpll_loop_pkg.sv
`include "adpll_macros.svh"

package adpll_loop_pkg;

    // cycle offset between reference and divided edge.
    typedef logic signed [`ADPLL_PDET_WIDTH-1:0] phase_err_t;

    // control word added to the oscillator bias.
    typedef logic signed [`ADPLL_DCO_CC_WIDTH-1:0] dco_cc_t;

    // integral path state.
    typedef logic signed [`ADPLL_INTEG_WIDTH-1:0] integ_t;

endpackage

// File: adpll_cfg_pkg.sv
`include "adpll_macros.svh"

package adpll_cfg_pkg;

    // register map.
    typedef enum logic [`ADPLL_CFG_ADDR_WIDTH-1:0] {
        ADDR_GAIN   = 2'd0,
        ADDR_WEIGHT = 2'd1,
        ADDR_BIAS   = 2'd2,
        ADDR_CTRL   = 2'd3
    } cfg_addr_e;

    // one data word, read as gains or as weights depending on the address.
    typedef union packed {
        struct packed {
            logic [7:0]                 reserved_hi;
            logic [`ADPLL_KI_WIDTH-1:0] ki;
            logic                       reserved_lo;
            logic [`ADPLL_KP_WIDTH-1:0] kp;
        } gain;
        struct packed {
            logic [`ADPLL_WEIGHT_WIDTH-1:0] below;
            logic [`ADPLL_WEIGHT_WIDTH-1:0] right;
            logic [`ADPLL_WEIGHT_WIDTH-1:0] above;
            logic [`ADPLL_WEIGHT_WIDTH-1:0] left;
        } weight;
    } cfg_word_u;

    // about 5 MHz out of a 258 MHz clock.
    localparam logic [`ADPLL_ACCUM_WIDTH-1:0] BIAS_RESET = 12'd76;

endpackage

// File: adpll_macros.svh
`ifndef ADPLL_MACROS_SVH
`define ADPLL_MACROS_SVH

// phase detector result width.
`define ADPLL_PDET_WIDTH 8

// oscillator phase accumulator.
`define ADPLL_ACCUM_WIDTH 12

// signed control word added to the bias.
`define ADPLL_DCO_CC_WIDTH 9

// neighbour weights, unsigned, in quarters.
`define ADPLL_WEIGHT_WIDTH 4
`define ADPLL_WEIGHT_SHIFT 2

// proportional gain, Q2.1.
`define ADPLL_KP_WIDTH 3
`define ADPLL_KP_FRAC 1

// integral gain, Q1.3.
`define ADPLL_KI_WIDTH 4
`define ADPLL_KI_FRAC 3

`define ADPLL_INTEG_WIDTH 16

// configuration write port.
`define ADPLL_CFG_ADDR_WIDTH 2
`define ADPLL_CFG_DATA_WIDTH 16

`endif
